/* testbench/coreTestdata.hex */
// One 32-bit hex word per entry. 0x000-0xFFF program and data image
// 0x1000 final PC, commit count, serial byte count, check count; 0x1010 serial bytes; 0x1040 address and word pairs
@0000
42000090 440001A8 06500000 663FFFF8
18880000 683FFFF8 2A500000 6A3FFFF8
3C500000 6C3FFFF8 4E3FFFE8 6E3FFFF8
// Loads and stores around 0x200
42001000 54400000 56400008 08980000
68400010 5A400010 6A3FFFF8 3D500000
6C400018 6C3FFFF8 667FFFF8
// Branch not taken, then taken over two words
7A800018 4E000208 6E3FFFF8 7B000018
4E0002C0 6E3FFFF8 4E0002D0 6E3FFFF8
// Count down loop, final store, halt
42000018 44000180 44800008 643FFFF8
427FFFF8 70400010 703FFFE0 66001020
80000000
@01FF
AAAAAAAA
11223344
0F0F00F0
55555555
66666666
77777777
@0FFF
A5A5A5A5
@1000
00000027
0000002F
0000000C
00000007
@1010
00000047 00000023 00000010 00000027
000000FD 00000034 00000070 00000041
0000005A 00000031 00000032 00000033
@1040
000001FF 0F0F00F0
00000200 11223344
00000201 0F0F00F0
00000202 20313434
00000203 31130770
00000204 0F0F00F0
00000FFF A5A5A5A5

/* filelist.f */
verilog/CoreTypes.sv
verilog/MemoryTypes.sv
verilog/RegisterFile.sv
verilog/ExecutionUnit.sv
verilog/MemoryAccessController.sv
verilog/Controller.sv
verilog/Core.sv
testbench/CoreTb.sv

/* testbench/CoreTb.sv */
/* Core testbench: memory model with random busy, latency and stray
   responses, checked against the program and results in the testdata file */
module CoreTb;
    import CoreTypes::*;
    import MemoryTypes::*;

    localparam PC_Path ResetPC = '0;
    localparam PhyAddrPath SerialAddr = '1;
    localparam int RandomSeed = 33;
    localparam int HaltTimeout = 20000;
    localparam int QuietCycles = 50;

    logic clk;
    logic rstN;
    MemAccessSerial nextMemReadSerial;
    MemWriteSerial nextMemWriteSerial;
    logic memAccessReadBusy;
    logic memAccessWriteBusy;
    MemReadResponse memReadResponse;
    MemWriteResponse memWriteResponse;
    PhyAddrPath memAccessAddr;
    MemoryEntryDataPath memAccessWriteData;
    logic memAccessRE;
    logic memAccessWE;
    logic serialWE;
    SerialDataPath serialWriteData;
    PC_Path lastCommittedPC;
    DebugRegister debugRegister;

    // Raw file words, then the memory seen by the core
    logic [31:0] fileWords [0:'h107F];
    MemoryEntryDataPath memImage [4096];
    SerialDataPath expectedSerial [$];
    PhyAddrPath checkAddrs [$];
    MemoryEntryDataPath checkWords [$];
    PC_Path expectedPC;
    DebugRegister expectedDebug;

    // Memory model state
    MemAccessSerial readSerialCount;
    MemWriteSerial writeSerialCount;
    logic readPending;
    MemAccessSerial readSerial;
    MemoryEntryDataPath readWord;
    int readDelay;
    logic writePending;
    MemWriteSerial writeSerial;
    int writeDelay;
    logic stalledRead;
    logic stalledWrite;
    PhyAddrPath stalledAddr;
    MemoryEntryDataPath stalledData;
    logic firstReadSeen;
    PhyAddrPath firstReadAddr;
    int serialIndex;

    Core #(
        .ResetPC(ResetPC),
        .SerialAddr(SerialAddr)
    ) dut_i (
        .clk(clk),
        .rstN(rstN),
        .nextMemReadSerial(nextMemReadSerial),
        .nextMemWriteSerial(nextMemWriteSerial),
        .memAccessReadBusy(memAccessReadBusy),
        .memAccessWriteBusy(memAccessWriteBusy),
        .memReadResponse(memReadResponse),
        .memWriteResponse(memWriteResponse),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE),
        .memAccessWE(memAccessWE),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .lastCommittedPC(lastCommittedPC),
        .debugRegister(debugRegister)
    );

    always #10 clk = ~clk;

    task automatic abortRun(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkSerial(input SerialDataPath got, input SerialDataPath expected,
            input string what);
        if (got !== expected) begin
            abortRun($sformatf("[ERROR] %0t: %s is %02h, expected %02h",
                $time, what, got, expected));
        end
    endtask

    task automatic checkWord(input MemoryEntryDataPath got,
            input MemoryEntryDataPath expected, input string what);
        if (got !== expected) begin
            abortRun($sformatf("[ERROR] %0t: %s is %08h, expected %08h",
                $time, what, got, expected));
        end
    endtask

    task automatic checkPC(input PC_Path got, input PC_Path expected, input string what);
        if (got !== expected) begin
            abortRun($sformatf("[ERROR] %0t: %s is %03h, expected %03h",
                $time, what, got, expected));
        end
    endtask

    task automatic checkDebug(input DebugRegister got, input DebugRegister expected,
            input string what);
        if (got !== expected) begin
            abortRun($sformatf("[ERROR] %0t: %s is halted %b count %0d, expected %b count %0d",
                $time, what, got.halted, got.commitCount, expected.halted,
                expected.commitCount));
        end
    endtask

    task automatic checkQuiet(input string when);
        if (memAccessRE !== 1'b0 || memAccessWE !== 1'b0 || serialWE !== 1'b0) begin
            abortRun($sformatf("memory request or serial output seen %s", when));
        end
    endtask

    task automatic loadTestData();
        int a;
        int serialCount;
        int checkCount;
        $readmemh("testbench/coreTestdata.hex", fileWords);
        if ($isunknown(fileWords['h1000])) begin
            abortRun("test data file could not be read");
        end
        for (a = 0; a < 4096; a++) begin
            if ($isunknown(fileWords[a])) begin
                memImage[a] = {4'hF, PhyAddrPath'(a), 4'h0, PhyAddrPath'(a)};
            end else begin
                memImage[a] = fileWords[a];
            end
        end
        expectedPC = PC_Path'(fileWords['h1000]);
        expectedDebug.halted = 1'b1;
        expectedDebug.commitCount = fileWords['h1001][15:0];
        serialCount = fileWords['h1002];
        checkCount = fileWords['h1003];
        for (a = 0; a < serialCount; a++) begin
            expectedSerial.push_back(SerialDataPath'(fileWords['h1010 + a]));
        end
        for (a = 0; a < checkCount; a++) begin
            checkAddrs.push_back(PhyAddrPath'(fileWords['h1040 + 2 * a]));
            checkWords.push_back(fileWords['h1041 + 2 * a]);
        end
    endtask

    // One cycle of the memory, called just after each rising edge
    task automatic serviceMemory();
        logic readBusy;
        logic writeBusy;
        SerialDataPath expectedByte;
        if (stalledRead && (memAccessRE !== 1'b1 || memAccessAddr !== stalledAddr)) begin
            abortRun("read request dropped or changed while the memory was busy");
        end
        if (stalledWrite && (memAccessWE !== 1'b1 || memAccessAddr !== stalledAddr
                || memAccessWriteData !== stalledData)) begin
            abortRun("write request dropped or changed while the memory was busy");
        end
        readBusy = ($urandom % 4) == 0;
        writeBusy = ($urandom % 4) == 0;
        memAccessReadBusy = readBusy;
        memAccessWriteBusy = writeBusy;
        nextMemReadSerial = readSerialCount;
        nextMemWriteSerial = writeSerialCount;
        stalledRead = (memAccessRE === 1'b1) && readBusy;
        stalledWrite = (memAccessWE === 1'b1) && writeBusy;
        stalledAddr = memAccessAddr;
        stalledData = memAccessWriteData;

        memReadResponse = '0;
        if (readPending && readDelay == 0) begin
            memReadResponse.ready = 1'b1;
            memReadResponse.serial = readSerial;
            memReadResponse.data = readWord;
            readPending = 1'b0;
        end else begin
            if (readPending) readDelay--;
            // Stray id that nobody waits for
            if (($urandom % 5) == 0) begin
                memReadResponse.ready = 1'b1;
                memReadResponse.serial = readSerial ^ 4'h9;
                memReadResponse.data = ~readWord;
            end
        end
        memWriteResponse = '0;
        if (writePending && writeDelay == 0) begin
            memWriteResponse.valid = 1'b1;
            memWriteResponse.serial = writeSerial;
            writePending = 1'b0;
        end else begin
            if (writePending) writeDelay--;
            if (($urandom % 5) == 0) begin
                memWriteResponse.valid = 1'b1;
                memWriteResponse.serial = writeSerial ^ 4'h6;
            end
        end

        // Requests taken at the coming edge
        if (memAccessRE === 1'b1 && !readBusy) begin
            if (readPending || writePending) begin
                abortRun("read issued while another memory request was outstanding");
            end
            if (!firstReadSeen) begin
                firstReadSeen = 1'b1;
                firstReadAddr = memAccessAddr;
            end
            readPending = 1'b1;
            readSerial = readSerialCount;
            readWord = memImage[memAccessAddr];
            readDelay = $urandom_range(5, 0);
            readSerialCount++;
        end
        if (memAccessWE === 1'b1 && !writeBusy) begin
            if (readPending || writePending) begin
                abortRun("write issued while another memory request was outstanding");
            end
            if (memAccessAddr == SerialAddr) begin
                abortRun("memory write issued to the serial address");
            end
            memImage[memAccessAddr] = memAccessWriteData;
            writePending = 1'b1;
            writeSerial = writeSerialCount;
            writeDelay = $urandom_range(5, 0);
            writeSerialCount++;
        end

        if (serialWE === 1'b1) begin
            if (expectedSerial.size() == 0) begin
                abortRun("serial output produced more bytes than expected");
            end
            expectedByte = expectedSerial.pop_front();
            checkSerial(serialWriteData, expectedByte, $sformatf("serial byte %0d", serialIndex));
            serialIndex++;
        end
    endtask

    initial begin
        void'($urandom(RandomSeed));
        nextMemReadSerial = '0;
        nextMemWriteSerial = '0;
        memAccessReadBusy = 1'b0;
        memAccessWriteBusy = 1'b0;
        memReadResponse = '0;
        memWriteResponse = '0;
        readSerialCount = '0;
        writeSerialCount = '0;
        readPending = 1'b0;
        readSerial = '0;
        readWord = '0;
        readDelay = 0;
        writePending = 1'b0;
        writeSerial = '0;
        writeDelay = 0;
        stalledRead = 1'b0;
        stalledWrite = 1'b0;
        firstReadSeen = 1'b0;
        serialIndex = 0;
        forever begin
            @(posedge clk);
            #1;
            serviceMemory();
        end
    end

    initial begin
        int waitCycles;
        int i;
        clk = 1'b0;
        rstN = 1'b0;
        loadTestData();
        repeat (8) begin
            @(posedge clk);
            #1;
            checkQuiet("during reset");
        end
        rstN = 1'b1;

        waitCycles = 0;
        while (debugRegister.halted !== 1'b1 && waitCycles < HaltTimeout) begin
            @(posedge clk);
            #1;
            waitCycles++;
        end
        if (debugRegister.halted !== 1'b1) begin
            abortRun("core did not halt within the cycle limit");
        end
        if (expectedSerial.size() != 0) begin
            abortRun($sformatf("%0d expected serial bytes never came out", expectedSerial.size()));
        end
        checkPC(PC_Path'(firstReadAddr), ResetPC, "first fetch address");
        checkPC(lastCommittedPC, expectedPC, "last committed PC");
        checkDebug(debugRegister, expectedDebug, "debug register at halt");
        for (i = 0; i < checkAddrs.size(); i++) begin
            checkWord(memImage[checkAddrs[i]], checkWords[i],
                $sformatf("memory word %03h", checkAddrs[i]));
        end

        // Halted core stays silent
        repeat (QuietCycles) begin
            @(posedge clk);
            #1;
            checkQuiet("after halt");
        end
        checkDebug(debugRegister, expectedDebug, "debug register after halt");
        $display("TB PASSED");
        $finish;
    end

endmodule

/* verilog/Core.sv */
/* Processor core top level: connects the controller and the datapath
   blocks to the memory port, serial output and debug outputs */
module Core #(
    parameter CoreTypes::PC_Path ResetPC = '0,
    parameter MemoryTypes::PhyAddrPath SerialAddr = '1
) (
    input logic clk,
    input logic rstN,
    input MemoryTypes::MemAccessSerial nextMemReadSerial,
    input MemoryTypes::MemWriteSerial nextMemWriteSerial,
    input logic memAccessReadBusy,
    input logic memAccessWriteBusy,
    input MemoryTypes::MemReadResponse memReadResponse,
    input MemoryTypes::MemWriteResponse memWriteResponse,
    output MemoryTypes::PhyAddrPath memAccessAddr,
    output MemoryTypes::MemoryEntryDataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic serialWE,
    output MemoryTypes::SerialDataPath serialWriteData,
    output CoreTypes::PC_Path lastCommittedPC,
    output CoreTypes::DebugRegister debugRegister
);
    import CoreTypes::*;
    import MemoryTypes::*;

    MemRequest memRequest;
    logic memDone;
    MemoryEntryDataPath memReadData;
    DataPath aluResult;
    logic branchTaken;
    RegIndexPath rfReadIdx1;
    RegIndexPath rfReadIdx2;
    DataPath rfReadData1;
    DataPath rfReadData2;
    logic rfWE;
    RegIndexPath rfWriteIdx;
    DataPath rfWriteData;
    AluCommand aluCommand;
    logic aluStart;

    Controller #(
        .ResetPC(ResetPC)
    ) controller (
        .clk(clk),
        .rstN(rstN),
        .memDone(memDone),
        .readData(memReadData),
        .aluResult(aluResult),
        .branchTaken(branchTaken),
        .rfReadData1(rfReadData1),
        .rfReadData2(rfReadData2),
        .memRequest(memRequest),
        .rfReadIdx1(rfReadIdx1),
        .rfReadIdx2(rfReadIdx2),
        .rfWE(rfWE),
        .rfWriteIdx(rfWriteIdx),
        .rfWriteData(rfWriteData),
        .aluCommand(aluCommand),
        .aluStart(aluStart),
        .lastCommittedPC(lastCommittedPC),
        .debugRegister(debugRegister)
    );

    RegisterFile registerFile (
        .clk(clk),
        .rstN(rstN),
        .readIdx1(rfReadIdx1),
        .readIdx2(rfReadIdx2),
        .we(rfWE),
        .writeIdx(rfWriteIdx),
        .writeData(rfWriteData),
        .readData1(rfReadData1),
        .readData2(rfReadData2)
    );

    ExecutionUnit executionUnit (
        .clk(clk),
        .rstN(rstN),
        .start(aluStart),
        .command(aluCommand),
        .result(aluResult),
        .branchTaken(branchTaken)
    );

    MemoryAccessController #(
        .SerialAddr(SerialAddr)
    ) memoryAccessController (
        .clk(clk),
        .rstN(rstN),
        .request(memRequest),
        .nextMemReadSerial(nextMemReadSerial),
        .nextMemWriteSerial(nextMemWriteSerial),
        .memAccessReadBusy(memAccessReadBusy),
        .memAccessWriteBusy(memAccessWriteBusy),
        .memReadResponse(memReadResponse),
        .memWriteResponse(memWriteResponse),
        .memAccessAddr(memAccessAddr),
        .memAccessWriteData(memAccessWriteData),
        .memAccessRE(memAccessRE),
        .memAccessWE(memAccessWE),
        .serialWE(serialWE),
        .serialWriteData(serialWriteData),
        .done(memDone),
        .readData(memReadData)
    );

endmodule

/* verilog/Controller.sv */
/* Multi-cycle sequencer: fetch, decode, execute, memory and writeback
   of one instruction at a time, with commit tracking and halt */
module Controller #(
    parameter CoreTypes::PC_Path ResetPC = '0
) (
    input logic clk,
    input logic rstN,
    input logic memDone,
    input CoreTypes::DataPath readData,
    input CoreTypes::DataPath aluResult,
    input logic branchTaken,
    input CoreTypes::DataPath rfReadData1,
    input CoreTypes::DataPath rfReadData2,
    output MemoryTypes::MemRequest memRequest,
    output CoreTypes::RegIndexPath rfReadIdx1,
    output CoreTypes::RegIndexPath rfReadIdx2,
    output logic rfWE,
    output CoreTypes::RegIndexPath rfWriteIdx,
    output CoreTypes::DataPath rfWriteData,
    output CoreTypes::AluCommand aluCommand,
    output logic aluStart,
    output CoreTypes::PC_Path lastCommittedPC,
    output CoreTypes::DebugRegister debugRegister
);
    import CoreTypes::*;
    import MemoryTypes::*;

    typedef enum logic [2:0] {
        StateFetch,
        StateDecode,
        StateExecute,
        StateMemory,
        StateWriteback,
        StateHalted
    } ControllerState;

    ControllerState state;
    PC_Path pc;
    InsnWord insn;
    OpCode op;
    DataPath immExt;
    logic usesImm;
    logic writesReg;

    assign op = insn.r.opcode;
    assign immExt = {{13{insn.i.imm[18]}}, insn.i.imm};
    assign usesImm = op inside {OpAddImm, OpLoad, OpStore};
    assign writesReg = op inside {OpAdd, OpSub, OpAnd, OpXor, OpAddImm, OpLoad};

    // Store data and the second branch operand come from rd
    assign rfReadIdx1 = insn.r.rs1;
    assign rfReadIdx2 = (op == OpStore || op == OpBranchEq) ? insn.r.rd : insn.r.rs2;

    assign rfWE = (state == StateWriteback) && writesReg;
    assign rfWriteIdx = insn.r.rd;
    assign rfWriteData = (op == OpLoad) ? readData : aluResult;

    assign aluStart = (state == StateExecute);

    always_comb begin
        memRequest = '0;
        case (state)
            StateFetch: begin
                memRequest.read = 1'b1;
                memRequest.addr = PhyAddrPath'(pc);
            end
            StateMemory: begin
                memRequest.read = (op == OpLoad);
                memRequest.write = (op == OpStore);
                memRequest.addr = PhyAddrPath'(aluResult);
                memRequest.data = rfReadData2;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= StateFetch;
            pc <= ResetPC;
            lastCommittedPC <= ResetPC;
            debugRegister <= '0;
        end else begin
            case (state)
                StateFetch: begin
                    if (memDone) begin
                        state <= StateDecode;
                    end
                end
                StateDecode: state <= StateExecute;
                StateExecute: begin
                    if (op == OpLoad || op == OpStore) begin
                        state <= StateMemory;
                    end else begin
                        state <= StateWriteback;
                    end
                end
                StateMemory: begin
                    if (memDone) begin
                        state <= StateWriteback;
                    end
                end
                StateWriteback: begin
                    // Commit point
                    lastCommittedPC <= pc;
                    debugRegister.commitCount <= debugRegister.commitCount + 1'b1;
                    if (op == OpBranchEq && branchTaken) begin
                        pc <= PC_Path'(aluResult);
                    end else begin
                        pc <= pc + 1'b1;
                    end
                    if (op == OpHalt) begin
                        debugRegister.halted <= 1'b1;
                        state <= StateHalted;
                    end else begin
                        state <= StateFetch;
                    end
                end
                default: state <= StateHalted;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateFetch && memDone) begin
            insn <= readData;
        end
        if (state == StateDecode) begin
            aluCommand.opcode <= op;
            aluCommand.pc <= pc;
            aluCommand.offset <= PC_Path'(immExt);
            aluCommand.srcA <= rfReadData1;
            aluCommand.srcB <= usesImm ? immExt : rfReadData2;
        end
    end

endmodule

/* verilog/MemoryAccessController.sv */
/* Issues one memory read or write at a time, tracks its serial until the
   matching response, and turns stores to the serial address into output bytes */
module MemoryAccessController #(
    parameter MemoryTypes::PhyAddrPath SerialAddr = '1
) (
    input logic clk,
    input logic rstN,
    input MemoryTypes::MemRequest request,
    input MemoryTypes::MemAccessSerial nextMemReadSerial,
    input MemoryTypes::MemWriteSerial nextMemWriteSerial,
    input logic memAccessReadBusy,
    input logic memAccessWriteBusy,
    input MemoryTypes::MemReadResponse memReadResponse,
    input MemoryTypes::MemWriteResponse memWriteResponse,
    output MemoryTypes::PhyAddrPath memAccessAddr,
    output MemoryTypes::MemoryEntryDataPath memAccessWriteData,
    output logic memAccessRE,
    output logic memAccessWE,
    output logic serialWE,
    output MemoryTypes::SerialDataPath serialWriteData,
    output logic done,
    output MemoryTypes::MemoryEntryDataPath readData
);
    import MemoryTypes::*;

    typedef enum logic [1:0] {
        MacIdle,
        MacRequest,
        MacWait,
        MacComplete
    } MacState;

    MacState state;
    logic isWrite;
    logic accepted;
    logic responded;
    MemAccessSerial readSerial;
    MemWriteSerial writeSerial;

    assign accepted = isWrite ? !memAccessWriteBusy : !memAccessReadBusy;
    assign responded = isWrite ?
        (memWriteResponse.valid && memWriteResponse.serial == writeSerial) :
        (memReadResponse.ready && memReadResponse.serial == readSerial);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= MacIdle;
            isWrite <= 1'b0;
            memAccessRE <= 1'b0;
            memAccessWE <= 1'b0;
            serialWE <= 1'b0;
            done <= 1'b0;
        end else begin
            serialWE <= 1'b0;
            done <= 1'b0;
            case (state)
                MacIdle: begin
                    if (request.write && request.addr == SerialAddr) begin
                        serialWE <= 1'b1;
                        done <= 1'b1;
                        state <= MacComplete;
                    end else if (request.read || request.write) begin
                        isWrite <= request.write;
                        memAccessRE <= !request.write;
                        memAccessWE <= request.write;
                        state <= MacRequest;
                    end
                end
                // Held until the memory is not busy
                MacRequest: begin
                    if (accepted) begin
                        memAccessRE <= 1'b0;
                        memAccessWE <= 1'b0;
                        state <= MacWait;
                    end
                end
                MacWait: begin
                    if (responded) begin
                        done <= 1'b1;
                        state <= MacComplete;
                    end
                end
                // Lets the controller drop its request
                default: state <= MacIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MacIdle) begin
            memAccessAddr <= request.addr;
            memAccessWriteData <= request.data;
            serialWriteData <= request.data[7:0];
        end
        if (state == MacRequest && accepted) begin
            readSerial <= nextMemReadSerial;
            writeSerial <= nextMemWriteSerial;
        end
        if (state == MacWait && responded && !isWrite) begin
            readData <= memReadResponse.data;
        end
    end

endmodule

/* verilog/ExecutionUnit.sv */
/* Registered ALU with address generation and
   branch target and compare */
module ExecutionUnit (
    input logic clk,
    input logic rstN,
    input logic start,
    input CoreTypes::AluCommand command,
    output CoreTypes::DataPath result,
    output logic branchTaken
);
    import CoreTypes::*;

    DataPath aluOut;
    PC_Path target;

    assign target = command.pc + command.offset;

    always_comb begin
        case (command.opcode)
            OpSub: aluOut = command.srcA - command.srcB;
            OpAnd: aluOut = command.srcA & command.srcB;
            OpXor: aluOut = command.srcA ^ command.srcB;
            // Also base plus immediate for loads and stores
            OpAdd, OpAddImm, OpLoad, OpStore: begin
                aluOut = command.srcA + command.srcB;
            end
            OpBranchEq: aluOut = DataPath'(target);
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            branchTaken <= 1'b0;
        end else if (start) begin
            branchTaken <= (command.opcode == OpBranchEq) && (command.srcA == command.srcB);
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= aluOut;
        end
    end

endmodule

/* verilog/RegisterFile.sv */
/* Eight-word register file, two combinational read ports
   and one write port, r0 reads as zero */
module RegisterFile (
    input logic clk,
    input logic rstN,
    input CoreTypes::RegIndexPath readIdx1,
    input CoreTypes::RegIndexPath readIdx2,
    input logic we,
    input CoreTypes::RegIndexPath writeIdx,
    input CoreTypes::DataPath writeData,
    output CoreTypes::DataPath readData1,
    output CoreTypes::DataPath readData2
);
    import CoreTypes::*;

    DataPath regs [8];

    assign readData1 = regs[readIdx1];
    assign readData2 = regs[readIdx2];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (we && writeIdx != '0) begin
            // r0 never written
            regs[writeIdx] <= writeData;
        end
    end

endmodule

/* verilog/MemoryTypes.sv */
/* Memory port types: addresses, data, request serials and
   the response structs of the outside memory */
package MemoryTypes;

    typedef logic [11:0] PhyAddrPath;
    typedef logic [31:0] MemoryEntryDataPath;

    // Ids assigned by the memory to accepted requests
    typedef logic [3:0] MemAccessSerial;
    typedef logic [3:0] MemWriteSerial;

    typedef logic [7:0] SerialDataPath;

    typedef struct packed {
        logic ready;
        MemAccessSerial serial;
        MemoryEntryDataPath data;
    } MemReadResponse;

    typedef struct packed {
        logic valid;
        MemWriteSerial serial;
    } MemWriteResponse;

    // Held by the controller until done
    typedef struct packed {
        logic read;
        logic write;
        PhyAddrPath addr;
        MemoryEntryDataPath data;
    } MemRequest;

endpackage

/* verilog/CoreTypes.sv */
/* Core types: data words, register indexes, PC, opcodes,
   instruction formats and the debug register */
package CoreTypes;

    typedef logic [31:0] DataPath;
    typedef logic [2:0] RegIndexPath;

    // Word-addressed program counter
    typedef logic [11:0] PC_Path;

    typedef enum logic [3:0] {
        OpAdd      = 4'd0,
        OpSub      = 4'd1,
        OpAnd      = 4'd2,
        OpXor      = 4'd3,
        OpAddImm   = 4'd4,
        OpLoad     = 4'd5,
        OpStore    = 4'd6,
        OpBranchEq = 4'd7,
        OpHalt     = 4'd8
    } OpCode;

    // Register-register format
    typedef struct packed {
        OpCode opcode;
        RegIndexPath rd;
        RegIndexPath rs1;
        RegIndexPath rs2;
        logic [18:0] padding;
    } InsnRType;

    // Immediate format, immediate sits over rs2 and the padding
    typedef struct packed {
        OpCode opcode;
        RegIndexPath rd;
        RegIndexPath rs1;
        logic signed [18:0] imm;
        logic [2:0] padding;
    } InsnIType;

    typedef union packed {
        InsnRType r;
        InsnIType i;
    } InsnWord;

    // Operands selected at decode.
    // Branches compare srcA with srcB and jump to pc + offset
    typedef struct packed {
        OpCode opcode;
        PC_Path pc;
        PC_Path offset;
        DataPath srcA;
        DataPath srcB;
    } AluCommand;

    typedef struct packed {
        logic halted;
        logic [15:0] commitCount;
    } DebugRegister;

endpackage
